// ==== hdl/nnCfg.svh ====
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

`define NN_INPUTS 10
`define NN_NEURONS 4
`define NN_FRAC 6
`define NN_ACT_MAX 127

// each neuron owns ten weights followed by its bias.
`define NN_WORDS 11

`define NN_WEIGHT_TABLE '{ \
	16'sd31, 16'sd14, -16'sd12, -16'sd8, -16'sd28, \
	16'sd19, 16'sd26, -16'sd31, 16'sd20, 16'sd8, -16'sd512, \
	-16'sd15, 16'sd22, 16'sd9, -16'sd27, 16'sd13, \
	16'sd30, -16'sd6, 16'sd17, -16'sd21, 16'sd11, 16'sd256, \
	16'sd7, -16'sd19, 16'sd28, 16'sd12, -16'sd9, \
	-16'sd24, 16'sd15, 16'sd5, 16'sd29, -16'sd14, -16'sd128, \
	-16'sd30, 16'sd3, 16'sd18, 16'sd25, 16'sd21, \
	-16'sd11, -16'sd17, 16'sd27, -16'sd4, -16'sd23, 16'sd64 \
}

`endif

// ==== hdl/nnTypesPkg.sv ====
`default_nettype none

`include "nnCfg.svh"

package nnTypesPkg;

	// activations and inputs share one signed byte format.
	typedef logic signed [7:0] actT;

	typedef logic signed [22:0] accT; // wide enough for ten products plus the bias.

	typedef actT [`NN_INPUTS-1:0] inVecT;

	typedef struct packed {
		actT [`NN_NEURONS-1:0] act;
		logic [$clog2(`NN_NEURONS)-1:0] winner; // index of the largest activation.
	} layerOutT;

endpackage

`default_nettype wire

// ==== hdl/weightBusPkg.sv ====
`default_nettype none

`include "nnCfg.svh"

package weightBusPkg;

	localparam int BUS_NODES = `NN_NEURONS;
	localparam int OWNER_W = $clog2(`NN_NEURONS);
	localparam int ADDR_W = $clog2(`NN_NEURONS * `NN_WORDS);

	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] addr;
	} weightReqT;

	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] addr;
		logic [OWNER_W-1:0] owner; // requester that the response goes back to.
	} romCmdT;

	typedef struct packed {
		logic valid;
		logic [OWNER_W-1:0] owner;
		logic signed [15:0] data;
	} weightRspT;

endpackage

`default_nettype wire

// ==== hdl/weightRom.sv ====
`default_nettype none

`include "nnCfg.svh"

module weightRom
	import weightBusPkg::*;
(
	input logic clk,
	input logic reset,
	input romCmdT cmd,
	output weightRspT rsp
);

	localparam int DEPTH = `NN_NEURONS * `NN_WORDS;
	localparam logic signed [15:0] WEIGHTS [DEPTH] = `NN_WEIGHT_TABLE;

	logic rspValid;
	logic [OWNER_W-1:0] rspOwner;
	logic signed [15:0] rspData;

	always_ff @(posedge clk)
	begin
		if (reset)
			rspValid <= 1'b0;
		else
			rspValid <= cmd.valid;
	end

	always_ff @(posedge clk)
	begin
		if (cmd.valid)
		begin
			rspOwner <= cmd.owner; // the tag follows the word so the owner can pick it off the bus.
			rspData <= WEIGHTS[cmd.addr];
		end
	end

	assign rsp = '{valid: rspValid, owner: rspOwner, data: rspData};

	// the arbiter passes neuron addresses through unchecked.
	addrInRange: assert property (@(posedge clk) disable iff (reset)
		cmd.valid |-> (int'(cmd.addr) < DEPTH));

endmodule

`default_nettype wire

// ==== hdl/weightArbiter.sv ====
`default_nettype none

module weightArbiter
	import weightBusPkg::*;
(
	input logic clk,
	input logic reset,
	input weightReqT [BUS_NODES-1:0] req,
	output logic [BUS_NODES-1:0] grant,
	output romCmdT cmd
);

	logic [OWNER_W-1:0] lastWin;
	logic [OWNER_W-1:0] winIdx;
	logic found;
	logic [BUS_NODES-1:0] reqValid;

	// search starts one past the last winner and wraps around.
	always_comb
	begin
		logic [OWNER_W-1:0] idx;
		found = 1'b0;
		winIdx = lastWin;
		idx = lastWin;
		for (int k = 0; k < BUS_NODES; k++)
		begin
			idx = idx + 1'b1;
			reqValid[idx] = req[idx].valid;
			if (!found && req[idx].valid)
			begin
				found = 1'b1;
				winIdx = idx;
			end
		end
	end

	assign grant = found ? (BUS_NODES'(1) << winIdx) : '0;
	assign cmd = '{valid: found, addr: req[winIdx].addr, owner: winIdx};

	always_ff @(posedge clk)
	begin
		if (reset)
			lastWin <= '1; // node 0 gets first pick after reset.
		else if (found)
			lastWin <= winIdx;
	end

	grantOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

	grantToValid: assert property (@(posedge clk) disable iff (reset)
		(grant & ~reqValid) == '0);

endmodule

`default_nettype wire

// ==== hdl/neuronMac.sv ====
`default_nettype none

`include "nnCfg.svh"

module neuronMac
	import nnTypesPkg::*;
	import weightBusPkg::*;
#(
	parameter int NODE_ID = 0
)
(
	input logic clk,
	input logic reset,
	input logic start,
	input inVecT inVec,
	output weightReqT req,
	input logic grant,
	input weightRspT rsp,
	output logic resultValid,
	output actT resultAct
);

	localparam int IDX_W = $clog2(`NN_WORDS + 1);
	localparam int LAST = `NN_WORDS - 1;
	localparam logic [ADDR_W-1:0] BASE = ADDR_W'(NODE_ID * `NN_WORDS);
	localparam logic [OWNER_W-1:0] MY_ID = OWNER_W'(NODE_ID);

	logic reqValid;
	logic [IDX_W-1:0] wordIdx;
	logic waiting;
	accT acc;

	logic granted;
	logic hit;
	logic [IDX_W-1:0] rspIdx;
	actT xIn;
	accT addend;
	accT nextAcc;
	logic signed [23:0] rounded;
	actT actOut;

	// #################### fetch

	assign req = '{valid: reqValid, addr: BASE + ADDR_W'(wordIdx)};
	assign granted = grant && reqValid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			reqValid <= 1'b0;
			wordIdx <= '0;
			waiting <= 1'b0;
		end
		else if (start)
		begin
			reqValid <= 1'b1;
			wordIdx <= '0;
			waiting <= 1'b0;
		end
		else
		begin
			waiting <= granted; // the ROM answers exactly one cycle after the grant.
			if (granted)
			begin
				wordIdx <= wordIdx + 1'b1;
				reqValid <= (wordIdx != IDX_W'(LAST));
			end
		end
	end

	// #################### accumulate

	// responses come back in order, so the pending word is one behind the fetch index.
	assign hit = rsp.valid && (rsp.owner == MY_ID);
	assign rspIdx = wordIdx - 1'b1;
	assign xIn = (rspIdx < IDX_W'(`NN_INPUTS)) ? inVec[rspIdx] : '0;
	assign addend = (rspIdx == IDX_W'(LAST)) ? accT'($signed(rsp.data))
		: accT'($signed(xIn)) * accT'($signed(rsp.data));
	assign nextAcc = acc + addend;

	always_ff @(posedge clk)
	begin
		if (start)
			acc <= '0;
		else if (hit)
			acc <= nextAcc;
	end

	// #################### activation

	assign rounded = ($signed({nextAcc[22], nextAcc}) + 24'sd32) >>> `NN_FRAC;

	always_comb
	begin
		if (nextAcc[22])
			actOut = '0;
		else if (rounded > 24'(`NN_ACT_MAX))
			actOut = actT'(`NN_ACT_MAX);
		else
			actOut = rounded[7:0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			resultValid <= 1'b0;
		else
			resultValid <= hit && (rspIdx == IDX_W'(LAST));
	end

	always_ff @(posedge clk)
	begin
		if (hit && (rspIdx == IDX_W'(LAST)))
			resultAct <= actOut;
	end

	// a stray tag would corrupt the sum of another node.
	rspExpected: assert property (@(posedge clk) disable iff (reset) hit |-> waiting);

endmodule

`default_nettype wire

// ==== hdl/layerCollect.sv ====
`default_nettype none

`include "nnCfg.svh"

module layerCollect
	import nnTypesPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input inVecT inVec,
	output logic neuronStart,
	output inVecT neuronVec,
	input logic [`NN_NEURONS-1:0] resultValid,
	input actT [`NN_NEURONS-1:0] resultAct,
	output logic busy,
	output logic done,
	output layerOutT result
);

	localparam int WIN_W = $clog2(`NN_NEURONS);

	logic [`NN_NEURONS-1:0] got;
	actT [`NN_NEURONS-1:0] acts;
	actT [`NN_NEURONS-1:0] actNext;
	logic [WIN_W-1:0] win;
	logic allIn;

	// #################### argmax

	always_comb
	begin
		actT best;
		for (int i = 0; i < `NN_NEURONS; i++)
			actNext[i] = resultValid[i] ? resultAct[i] : acts[i];
		best = actNext[0];
		win = '0;
		for (int i = 1; i < `NN_NEURONS; i++)
		begin
			if ($signed(actNext[i]) > $signed(best)) // strict compare keeps the lower index on a tie.
			begin
				best = actNext[i];
				win = WIN_W'(i);
			end
		end
	end

	assign allIn = &(got | resultValid);

	// #################### control

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			neuronStart <= 1'b0;
			done <= 1'b0;
			got <= '0;
			result <= '0;
		end
		else
		begin
			neuronStart <= 1'b0;
			done <= 1'b0;
			if (start && !busy)
			begin
				busy <= 1'b1;
				neuronStart <= 1'b1;
				got <= '0;
			end
			else if (busy)
			begin
				got <= got | resultValid;
				if (allIn)
				begin
					busy <= 1'b0;
					done <= 1'b1;
					result <= '{act: actNext, winner: win};
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start && !busy)
			neuronVec <= inVec; // held for the whole run since the neurons read it per word.
		for (int i = 0; i < `NN_NEURONS; i++)
			if (resultValid[i])
				acts[i] <= resultAct[i];
	end

	singleReport: assert property (@(posedge clk) disable iff (reset)
		busy |-> ((got & resultValid) == '0));

endmodule

`default_nettype wire

// ==== hdl/nnLayer.sv ====
`default_nettype none

module nnLayer
	import nnTypesPkg::*;
	import weightBusPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input inVecT inVec,
	output logic busy,
	output logic done,
	output layerOutT result
);

	logic neuronStart;
	inVecT neuronVec;
	weightReqT [BUS_NODES-1:0] req;
	logic [BUS_NODES-1:0] grant;
	romCmdT cmd;
	weightRspT rsp;
	logic [BUS_NODES-1:0] resultValid;
	actT [BUS_NODES-1:0] resultAct;

	layerCollect layerCollect_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.inVec(inVec),
		.neuronStart(neuronStart),
		.neuronVec(neuronVec),
		.resultValid(resultValid),
		.resultAct(resultAct),
		.busy(busy),
		.done(done),
		.result(result)
	);

	// every node sees the same response bus and filters on the owner tag.
	for (genvar i = 0; i < BUS_NODES; i++)
	begin : genNode
		neuronMac #(.NODE_ID(i)) neuronMac_i (
			.clk(clk),
			.reset(reset),
			.start(neuronStart),
			.inVec(neuronVec),
			.req(req[i]),
			.grant(grant[i]),
			.rsp(rsp),
			.resultValid(resultValid[i]),
			.resultAct(resultAct[i])
		);
	end

	weightArbiter weightArbiter_i (
		.clk(clk),
		.reset(reset),
		.req(req),
		.grant(grant),
		.cmd(cmd)
	);

	weightRom weightRom_i (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.rsp(rsp)
	);

endmodule

`default_nettype wire

// ==== dv/nnLayerTb.sv ====
`default_nettype none

`include "nnCfg.svh"

module nnLayerTb
	import nnTypesPkg::*;
();

	localparam int RUN_LIMIT = 60;
	localparam int RUNS = 46; // 45 vectors plus the idle window after the ignored start.
	localparam int CYCLE_LIMIT = RUNS * RUN_LIMIT + 100;
	localparam logic signed [15:0] WEIGHTS [`NN_NEURONS * `NN_WORDS] = `NN_WEIGHT_TABLE;

	logic clk;
	logic reset;
	logic start;
	inVecT inVec;
	logic busy;
	logic done;
	layerOutT result;

	int errors = 0;
	int cycleCount = 0;
	int seed = 32'h65dd;

	nnLayer nnLayer_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.inVec(inVec),
		.busy(busy),
		.done(done),
		.result(result)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("simulation ran past %0d cycles without finishing", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// #################### model

	function automatic int neuronModel(input int n, input inVecT v);
		int sum;
		int rounded;
		sum = int'(WEIGHTS[n * `NN_WORDS + `NN_INPUTS]); // the bias word follows the weights.
		for (int i = 0; i < `NN_INPUTS; i++)
			sum += int'(v[i]) * int'(WEIGHTS[n * `NN_WORDS + i]);
		if (sum < 0)
			return 0;
		rounded = (sum + (1 << (`NN_FRAC - 1))) >>> `NN_FRAC;
		if (rounded > `NN_ACT_MAX)
			return `NN_ACT_MAX;
		return rounded;
	endfunction

	function automatic int winnerModel(input inVecT v);
		int best;
		int idx;
		best = neuronModel(0, v);
		idx = 0;
		for (int n = 1; n < `NN_NEURONS; n++)
			if (neuronModel(n, v) > best)
			begin
				best = neuronModel(n, v);
				idx = n;
			end
		return idx;
	endfunction

	// each input follows the sign of its weight, scaled by mag.
	function automatic inVecT signVec(input int n, input int mag);
		inVecT v;
		for (int i = 0; i < `NN_INPUTS; i++)
			v[i] = (WEIGHTS[n * `NN_WORDS + i] >= 0) ? actT'(mag) : actT'(-mag);
		return v;
	endfunction

	// #################### helpers

	task automatic nextCycle();
		@(posedge clk);
		#5;
	endtask

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic compareResult(input inVecT v);
		for (int n = 0; n < `NN_NEURONS; n++)
			checkValue($sformatf("result.act[%0d]", n), 64'(result.act[n]), 64'(neuronModel(n, v)));
		checkValue("result.winner", 64'(result.winner), 64'(winnerModel(v)));
	endtask

	task automatic runVector(input inVecT v);
		int waitCount;
		start = 1'b1;
		inVec = v;
		nextCycle();
		start = 1'b0;
		checkValue("busy", 64'(busy), 64'd1);
		waitCount = 0;
		while (!done && waitCount < RUN_LIMIT)
		begin
			nextCycle();
			waitCount++;
			if (!done)
				checkValue("busy", 64'(busy), 64'd1);
		end
		if (!done)
		begin
			$display("done did not arrive within %0d cycles of start", RUN_LIMIT);
			errors++;
		end
		else
		begin
			checkValue("busy", 64'(busy), 64'd0);
			compareResult(v);
		end
	endtask

	// #################### tests

	task automatic resetState();
		checkValue("busy", 64'(busy), 64'd0);
		checkValue("done", 64'(done), 64'd0);
		checkValue("result", 64'(result), 64'd0);
	endtask

	task automatic referenceCases();
		runVector('0);
		checkValue("result.act[0]", 64'(result.act[0]), 64'd0);
		runVector(signVec(0, 10)); // sum 1458 rounds to 23.
		checkValue("result.act[0]", 64'(result.act[0]), 64'd23);
	endtask

	task automatic rectifierCases();
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			runVector(signVec(n, -127));
			checkValue($sformatf("result.act[%0d]", n), 64'(result.act[n]), 64'd0);
		end
	endtask

	task automatic saturationCases();
		inVecT v;
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			runVector(signVec(n, 127));
			checkValue($sformatf("result.act[%0d]", n), 64'(result.act[n]), 64'd127);
		end
		v = '0;
		v[0] = 8'sd127;
		v[6] = 8'sd127;
		v[8] = 8'sd72; // sum 8167 rounds to 128, one past the limit.
		runVector(v);
		checkValue("result.act[0]", 64'(result.act[0]), 64'd127);
	endtask

	task automatic roundingCases();
		inVecT v;
		v = '0;
		v[0] = 8'sd32; // sum 480, low bits 32, rounds up to 8.
		runVector(v);
		checkValue("result.act[0]", 64'(result.act[0]), 64'd8);
		v[0] = 8'sd65; // sum 1503, low bits 31, rounds down to 23.
		runVector(v);
		checkValue("result.act[0]", 64'(result.act[0]), 64'd23);
	endtask

	task automatic randomVectors();
		inVecT v;
		for (int r = 0; r < 30; r++)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
				v[i] = actT'($random(seed));
			runVector(v);
		end
	endtask

	task automatic ignoredStart();
		inVecT first;
		int doneCount;
		int waitCount;
		first = signVec(2, 50);
		start = 1'b1;
		inVec = first;
		nextCycle();
		start = 1'b0;
		repeat (3) nextCycle();
		checkValue("busy", 64'(busy), 64'd1);
		start = 1'b1;
		inVec = signVec(2, -50);
		nextCycle();
		start = 1'b0;
		doneCount = 0;
		waitCount = 0;
		while (doneCount == 0 && waitCount < RUN_LIMIT)
		begin
			nextCycle();
			waitCount++;
			if (done)
				doneCount++;
		end
		if (doneCount == 0)
		begin
			$display("done did not arrive after the first of two starts");
			errors++;
		end
		else
			compareResult(first);
		repeat (RUN_LIMIT)
		begin
			nextCycle();
			if (done)
				doneCount++;
		end
		checkValue("done count", 64'(doneCount), 64'd1);
	endtask

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		inVec = '0;
		repeat (10) @(posedge clk);
		#5;
		reset = 1'b0;
		resetState();
		referenceCases();
		rectifierCases();
		saturationCases();
		roundingCases();
		randomVectors();
		ignoredStart();
		$display("%0d errors", errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/nnTypesPkg.sv
hdl/weightBusPkg.sv
hdl/weightRom.sv
hdl/weightArbiter.sv
hdl/neuronMac.sv
hdl/layerCollect.sv
hdl/nnLayer.sv
dv/nnLayerTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= nnLayerTb
FLIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^ALL CHECKS PASSED$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
